/* hw/exu_pkg.sv */
package exu_pkg;

    // datapath width
    localparam int xlen = 64;

    // cycles spent iterating in the mul/div unit
    localparam int muldiv_steps = 64;

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_pass_a = 5'd2,
        alu_pass_b = 5'd3,
        alu_xor    = 5'd4,
        alu_or     = 5'd5,
        alu_and    = 5'd6,
        alu_sll    = 5'd7,
        alu_srl    = 5'd8,
        alu_sra    = 5'd9,
        alu_slt    = 5'd10,
        alu_sltu   = 5'd11,
        alu_eq     = 5'd12,
        alu_ge     = 5'd13,
        alu_geu    = 5'd14,
        alu_mul    = 5'd15,
        alu_div    = 5'd16,
        alu_divu   = 5'd17,
        alu_rem    = 5'd18,
        alu_remu   = 5'd19
    } alu_op_t;

    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_t;

    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_t;

    // one bit per opcode, set for those handled by the iterative unit
    localparam logic [31:0] is_muldiv = (32'd1 << alu_mul) | (32'd1 << alu_div) |
                                        (32'd1 << alu_divu) | (32'd1 << alu_rem) |
                                        (32'd1 << alu_remu);

    // shared accumulator, read as a product or as remainder/quotient
    typedef union packed {
        struct packed {
            logic [xlen-1:0] hi;
            logic [xlen-1:0] lo;
        } prod;
        struct packed {
            logic [xlen-1:0] rem;
            logic [xlen-1:0] quo;
        } qr;
    } muldiv_acc_u;

endpackage

/* hw/exu_csr_pkg.sv */
package exu_csr_pkg;

    // wishbone port geometry
    localparam int wb_aw = 4;
    localparam int wb_dw = 32;

    // register map, byte addresses
    localparam logic [wb_aw-1:0] addr_ctrl       = 4'h0;
    localparam logic [wb_aw-1:0] addr_scratch_lo = 4'h4;
    localparam logic [wb_aw-1:0] addr_scratch_hi = 4'h8;
    localparam logic [wb_aw-1:0] addr_retired    = 4'hC;

    // retire counter width, read-only from the bus
    localparam int retired_w = 32;

    // control register fields
    localparam int ctrl_m_en_bit = 0;

    // M extension on out of reset
    localparam logic [wb_dw-1:0] ctrl_reset_value = 32'd1 << ctrl_m_en_bit;

endpackage

/* hw/exu_csr_regs.sv */
module exu_csr_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [exu_csr_pkg::wb_aw-1:0]   wb_adr,
    input  logic [exu_csr_pkg::wb_dw-1:0]   wb_dat_w,
    input  logic                            retire,
    output logic [exu_csr_pkg::wb_dw-1:0]   wb_dat_r,
    output logic                            wb_ack,
    output logic                            m_en,
    output logic [exu_pkg::xlen-1:0]        csr_operand
);

    logic                                 req;
    logic [exu_csr_pkg::wb_dw-1:0]        ctrl_q;
    logic [exu_csr_pkg::wb_dw-1:0]        scratch_lo_q;
    logic [exu_csr_pkg::wb_dw-1:0]        scratch_hi_q;
    logic [exu_csr_pkg::retired_w-1:0]    retired_q;

    // new request, the cycle before ack goes out
    assign req = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack       <= 1'b0;
            ctrl_q       <= exu_csr_pkg::ctrl_reset_value;
            scratch_lo_q <= '0;
            scratch_hi_q <= '0;
        end else begin
            wb_ack <= req;
            if (req && wb_we) begin
                case (wb_adr)
                    exu_csr_pkg::addr_ctrl:       ctrl_q       <= wb_dat_w;
                    exu_csr_pkg::addr_scratch_lo: scratch_lo_q <= wb_dat_w;
                    exu_csr_pkg::addr_scratch_hi: scratch_hi_q <= wb_dat_w;
                    // retire count and holes ignore writes
                    default: ;
                endcase
            end
        end
    end

    // wraps naturally at all ones
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retired_q <= '0;
        end else if (retire) begin
            retired_q <= retired_q + 1'b1;
        end
    end

    // read data only matters while ack is high
    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                exu_csr_pkg::addr_ctrl:       wb_dat_r <= ctrl_q;
                exu_csr_pkg::addr_scratch_lo: wb_dat_r <= scratch_lo_q;
                exu_csr_pkg::addr_scratch_hi: wb_dat_r <= scratch_hi_q;
                exu_csr_pkg::addr_retired:    wb_dat_r <= retired_q;
                default:                      wb_dat_r <= '0;
            endcase
        end
    end

    assign m_en        = ctrl_q[exu_csr_pkg::ctrl_m_en_bit];
    assign csr_operand = {scratch_hi_q, scratch_lo_q};

endmodule

/* hw/exu_muldiv.sv */
module exu_muldiv (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  exu_pkg::alu_op_t         op,
    input  logic [exu_pkg::xlen-1:0] a,
    input  logic [exu_pkg::xlen-1:0] b,
    input  logic                     flush,
    output logic                     done,
    output logic [exu_pkg::xlen-1:0] result
);

    localparam int xlen  = exu_pkg::xlen;
    localparam int cnt_w = $clog2(exu_pkg::muldiv_steps);

    exu_pkg::muldiv_acc_u acc;
    exu_pkg::muldiv_acc_u acc_next;

    logic             running;
    logic             finishing;
    logic [cnt_w-1:0] cnt;
    logic             is_signed;
    logic             is_mul;
    logic             a_neg;
    logic             b_neg;
    logic [xlen-1:0]  a_abs;
    logic [xlen-1:0]  b_abs;
    logic [xlen:0]    sum;
    logic [xlen:0]    shifted;
    logic [xlen:0]    diff;
    logic [xlen-1:0]  quo_fix;
    logic [xlen-1:0]  rem_fix;

    // latched at start
    logic [xlen-1:0]  opnd_q;
    logic [xlen-1:0]  dividend_q;
    logic             is_mul_q;
    logic             want_rem_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             div0_q;

    assign is_signed = (op == exu_pkg::alu_div) || (op == exu_pkg::alu_rem);
    assign is_mul    = (op == exu_pkg::alu_mul);
    assign a_neg     = is_signed & a[xlen-1];
    assign b_neg     = is_signed & b[xlen-1];
    assign a_abs     = a_neg ? -a : a;
    assign b_abs     = b_neg ? -b : b;

    // one radix-2 step, shift-add for mul or restoring shift-subtract for div
    assign sum     = {1'b0, acc.prod.hi} + (acc.prod.lo[0] ? {1'b0, opnd_q} : '0);
    assign shifted = {acc.qr.rem, acc.qr.quo[xlen-1]};
    assign diff    = shifted - {1'b0, opnd_q};

    always_comb begin
        acc_next = acc;
        if (is_mul_q) begin
            acc_next = {sum, acc.prod.lo[xlen-1:1]};
        end else if (!diff[xlen]) begin
            acc_next.qr.rem = diff[xlen-1:0];
            acc_next.qr.quo = {acc.qr.quo[xlen-2:0], 1'b1};
        end else begin
            acc_next.qr.rem = shifted[xlen-1:0];
            acc_next.qr.quo = {acc.qr.quo[xlen-2:0], 1'b0};
        end
    end

    // min / -1 needs no special case, the magnitudes already give back the dividend
    assign quo_fix = neg_quo_q ? -acc.qr.quo : acc.qr.quo;
    assign rem_fix = neg_rem_q ? -acc.qr.rem : acc.qr.rem;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            finishing <= 1'b0;
            done      <= 1'b0;
            cnt       <= '0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                running   <= 1'b0;
                finishing <= 1'b0;
            end else if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(exu_pkg::muldiv_steps - 1)) begin
                    running   <= 1'b0;
                    finishing <= 1'b1;
                end
            end else if (finishing) begin
                finishing <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc        <= {{xlen{1'b0}}, (is_mul ? a : a_abs)};
            opnd_q     <= is_mul ? b : b_abs;
            dividend_q <= a;
            is_mul_q   <= is_mul;
            want_rem_q <= (op == exu_pkg::alu_rem) || (op == exu_pkg::alu_remu);
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            div0_q     <= (b == '0);
        end else if (running) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (finishing) begin
            if (is_mul_q) begin
                result <= acc.prod.lo;
            end else if (div0_q) begin
                // divide by zero: all ones quotient, dividend as remainder
                result <= want_rem_q ? dividend_q : '1;
            end else begin
                result <= want_rem_q ? rem_fix : quo_fix;
            end
        end
    end

endmodule

/* hw/exu_alu.sv */
module exu_alu (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  exu_pkg::alu_op_t         op,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1,
    input  logic [exu_pkg::xlen-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic [exu_pkg::xlen-1:0] csr_operand,
    input  exu_pkg::sel_a_t          sel_a,
    input  exu_pkg::sel_b_t          sel_b,
    input  logic                     word,
    input  logic                     flush,
    input  logic                     m_en,
    output logic [exu_pkg::xlen-1:0] res,
    output logic                     res_valid,
    output logic                     busy,
    output logic                     illegal
);

    localparam int xlen = exu_pkg::xlen;

    logic [xlen-1:0] a_op;
    logic [xlen-1:0] b_op;
    logic [5:0]      shamt;
    logic [31:0]     sra_word;
    logic [xlen-1:0] alu_res;
    logic            accept;
    logic            op_is_md;
    logic            md_start;
    logic            md_done;
    logic [xlen-1:0] md_result;
    logic [xlen-1:0] res_q;
    logic            res_valid_q;
    logic            illegal_q;
    logic            busy_q;

    // rs1 is zero-extended from 32 bits in word mode
    assign a_op = (sel_a == exu_pkg::sel_a_rs1) ? (word ? {32'b0, rs1[31:0]} : rs1) : pc;

    always_comb begin
        case (sel_b)
            exu_pkg::sel_b_rs2: b_op = rs2;
            exu_pkg::sel_b_csr: b_op = csr_operand;
            default:            b_op = imm;
        endcase
    end

    assign shamt    = b_op[5:0];
    assign sra_word = $signed(a_op[31:0]) >>> shamt;

    always_comb begin
        case (op)
            exu_pkg::alu_add:    alu_res = a_op + b_op;
            exu_pkg::alu_sub:    alu_res = a_op - b_op;
            exu_pkg::alu_pass_a: alu_res = a_op;
            exu_pkg::alu_pass_b: alu_res = b_op;
            exu_pkg::alu_xor:    alu_res = a_op ^ b_op;
            exu_pkg::alu_or:     alu_res = a_op | b_op;
            exu_pkg::alu_and:    alu_res = a_op & b_op;
            exu_pkg::alu_sll:    alu_res = a_op << shamt;
            exu_pkg::alu_srl:    alu_res = a_op >> shamt;
            exu_pkg::alu_sra: begin
                if (word) begin
                    alu_res = {32'b0, sra_word};
                end else begin
                    alu_res = $signed(a_op) >>> shamt;
                end
            end
            exu_pkg::alu_slt:    alu_res = {63'b0, $signed(a_op) < $signed(b_op)};
            exu_pkg::alu_sltu:   alu_res = {63'b0, a_op < b_op};
            exu_pkg::alu_eq:     alu_res = {63'b0, a_op == b_op};
            exu_pkg::alu_ge:     alu_res = {63'b0, $signed(a_op) >= $signed(b_op)};
            exu_pkg::alu_geu:    alu_res = {63'b0, a_op >= b_op};
            default:             alu_res = '0;
        endcase
    end

    // flush also drops anything issued alongside it
    assign accept   = in_valid & ~busy & ~flush;
    assign op_is_md = exu_pkg::is_muldiv[op];
    assign md_start = accept & op_is_md & m_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid_q <= 1'b0;
            illegal_q   <= 1'b0;
            busy_q      <= 1'b0;
        end else begin
            res_valid_q <= accept & (~op_is_md | ~m_en);
            illegal_q   <= accept & op_is_md & ~m_en;
            if (flush) begin
                busy_q <= 1'b0;
            end else if (md_start) begin
                busy_q <= 1'b1;
            end else if (md_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // illegal mul/div returns zero
    always_ff @(posedge clk) begin
        if (accept) begin
            res_q <= op_is_md ? '0 : alu_res;
        end
    end

    exu_muldiv u_muldiv (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (md_start),
        .op     (op),
        .a      (a_op),
        .b      (b_op),
        .flush  (flush),
        .done   (md_done),
        .result (md_result)
    );

    // busy drops in the same cycle the iterative result shows up
    assign busy      = busy_q & ~md_done;
    assign res_valid = res_valid_q | md_done;
    assign res       = md_done ? md_result : res_q;
    assign illegal   = illegal_q;

endmodule

/* hw/exu_top.sv */
module exu_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  exu_pkg::alu_op_t              op,
    input  logic [exu_pkg::xlen-1:0]      pc,
    input  logic [exu_pkg::xlen-1:0]      rs1,
    input  logic [exu_pkg::xlen-1:0]      rs2,
    input  logic [exu_pkg::xlen-1:0]      imm,
    input  exu_pkg::sel_a_t               sel_a,
    input  exu_pkg::sel_b_t               sel_b,
    input  logic                          word,
    input  logic                          flush,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [exu_csr_pkg::wb_aw-1:0] wb_adr,
    input  logic [exu_csr_pkg::wb_dw-1:0] wb_dat_w,
    output logic [exu_pkg::xlen-1:0]      res,
    output logic                          res_valid,
    output logic                          busy,
    output logic                          illegal,
    output logic [exu_csr_pkg::wb_dw-1:0] wb_dat_r,
    output logic                          wb_ack
);

    logic                       m_en;
    logic [exu_pkg::xlen-1:0]   csr_operand;

    // config block, counts every result the alu hands out
    exu_csr_regs u_csr (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .retire      (res_valid),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .m_en        (m_en),
        .csr_operand (csr_operand)
    );

    exu_alu u_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .op          (op),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .csr_operand (csr_operand),
        .sel_a       (sel_a),
        .sel_b       (sel_b),
        .word        (word),
        .flush       (flush),
        .m_en        (m_en),
        .res         (res),
        .res_valid   (res_valid),
        .busy        (busy),
        .illegal     (illegal)
    );

endmodule

/* testbench/exu_monitor.sv */
module exu_monitor (
    input logic                     clk,
    input logic                     arst_n,
    input logic [exu_pkg::xlen-1:0] res,
    input logic                     res_valid,
    input logic                     illegal
);

    timeunit 1ns;
    timeprecision 100ps;

    // expectations in issue order
    string                    exp_name[$];
    logic [exu_pkg::xlen-1:0] exp_val[$];
    bit                       exp_ill[$];

    int value_errors = 0;
    int other_errors = 0;
    int n_results    = 0;

    task automatic push(input string name, input logic [exu_pkg::xlen-1:0] val, input bit ill);
        exp_name.push_back(name);
        exp_val.push_back(val);
        exp_ill.push_back(ill);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        string                    name;
        logic [exu_pkg::xlen-1:0] val;
        bit                       ill;
        if (arst_n && res_valid) begin
            n_results++;
            if (exp_val.size() == 0) begin
                $display("a result %h arrived with no expected value queued", res);
                other_errors++;
            end else begin
                name = exp_name.pop_front();
                val  = exp_val.pop_front();
                ill  = exp_ill.pop_front();
                check_value(name, val, res);
                if (ill && !illegal) begin
                    $display("the illegal flag is missing on %s", name);
                    other_errors++;
                end else if (!ill && illegal) begin
                    $display("the illegal flag was raised on %s, a legal operation", name);
                    other_errors++;
                end
            end
        end
    end

endmodule

/* testbench/exu_chk.sv */
module exu_chk (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic busy,
    input logic flush,
    input logic md_op,
    input logic m_en,
    input logic res_valid,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;

    logic issue;
    assign issue = in_valid & ~busy & ~flush;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n) in_valid |-> !busy)
        else begin $error("an operation was issued while busy was high"); fails++; end

    a_single_lat: assert property (@(posedge clk) disable iff (!arst_n)
        (issue && !(md_op && m_en)) |=> res_valid)
        else begin $error("single-cycle result did not follow its issue"); fails++; end

    // busy for 65 sampled cycles, result on the 66th
    a_md_lat: assert property (@(posedge clk) disable iff (!arst_n || flush)
        (issue && md_op && m_en) |=> busy [*65] ##1 (res_valid && !busy))
        else begin $error("mul/div result was not 66 cycles after issue"); fails++; end

    a_flush_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (!res_valid until in_valid))
        else begin $error("a result appeared after a flush"); fails++; end

    a_wb_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack ##1 !wb_ack)
        else begin $error("wishbone ack was not a single pulse one cycle late"); fails++; end

endmodule

bind exu_alu exu_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .busy      (busy),
    .flush     (flush),
    .md_op     (exu_pkg::is_muldiv[op]),
    .m_en      (m_en),
    .res_valid (res_valid),
    .wb_cyc    (1'b0),
    .wb_stb    (1'b0),
    .wb_ack    (1'b0)
);

bind exu_csr_regs exu_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (1'b0),
    .busy      (1'b0),
    .flush     (1'b0),
    .md_op     (1'b0),
    .m_en      (1'b0),
    .res_valid (retire),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack)
);

/* testbench/exu_tb.sv */
module exu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_rand     = 20;
    localparam int n_directed = 4;
    localparam exu_pkg::sel_a_t a_pc  = exu_pkg::sel_a_pc;
    localparam exu_pkg::sel_a_t a_rs1 = exu_pkg::sel_a_rs1;
    localparam exu_pkg::sel_b_t b_rs2 = exu_pkg::sel_b_rs2;
    localparam exu_pkg::sel_b_t b_imm = exu_pkg::sel_b_imm;
    localparam exu_pkg::sel_b_t b_csr = exu_pkg::sel_b_csr;
    localparam logic [63:0] csr_val = 64'h0000_0010_0000_0003;

    typedef struct packed {
        exu_pkg::alu_op_t op;
        exu_pkg::sel_a_t  sa;
        exu_pkg::sel_b_t  sb;
        logic             word;
        logic [63:0]      pc, rs1, rs2, imm, exp;
    } item_t;

    logic clk, arst_n, in_valid, word, flush;
    logic wb_cyc, wb_stb, wb_we, wb_ack, res_valid, busy, illegal;
    exu_pkg::alu_op_t op;
    exu_pkg::sel_a_t  sel_a;
    exu_pkg::sel_b_t  sel_b;
    logic [63:0] pc, rs1, rs2, imm, res;
    logic [exu_csr_pkg::wb_aw-1:0] wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r, rd;

    item_t tbl[$];
    string tbl_name[$];
    bit    tbl_ready = 0;
    int    tb_errors = 0;
    int    total;

    exu_top u_dut (.*);

    exu_monitor u_mon (.clk(clk), .arst_n(arst_n), .res(res), .res_valid(res_valid),
                       .illegal(illegal));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add(input string name, input exu_pkg::alu_op_t o, input exu_pkg::sel_a_t sa,
                       input exu_pkg::sel_b_t sb, input bit w, input logic [63:0] p, r1, r2,
                       input logic [63:0] im, ex);
        tbl.push_back('{o, sa, sb, w, p, r1, r2, im, ex});
        tbl_name.push_back(name);
    endtask

    task automatic issue(input string name, input item_t it, input bit ill, input bit track);
        @(posedge clk);
        while (busy) @(posedge clk);
        in_valid <= 1'b1;
        op       <= it.op;
        sel_a    <= it.sa;
        sel_b    <= it.sb;
        word     <= it.word;
        pc       <= it.pc;
        rs1      <= it.rs1;
        rs2      <= it.rs2;
        imm      <= it.imm;
        if (track) u_mon.push(name, it.exp, ill);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wb_access(input bit we, input logic [3:0] adr, input logic [31:0] wdat);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(posedge clk);
        while (!wb_ack && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!wb_ack) begin
            $display("wishbone access to %h never got an ack", adr);
            tb_errors++;
        end
        rd = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (busy || u_mon.exp_val.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    // expected mul/div result from the RISC-V rules
    function automatic logic [63:0] ref_muldiv(exu_pkg::alu_op_t o, logic [63:0] a, b);
        longint sa, sb;
        sa = a;
        sb = b;
        case (o)
            exu_pkg::alu_mul:  return a * b;
            exu_pkg::alu_divu: return (b == 0) ? '1 : a / b;
            exu_pkg::alu_remu: return (b == 0) ? a : a % b;
            exu_pkg::alu_div:
                if (b == 0) return '1;
                else if (a == 64'h8000_0000_0000_0000 && b == '1) return a;
                else return sa / sb;
            default:
                if (b == 0) return a;
                else if (a == 64'h8000_0000_0000_0000 && b == '1) return 0;
                else return sa % sb;
        endcase
    endfunction

    initial begin
        wait (tbl_ready);
        repeat ((tbl.size() + n_rand + n_directed) * 70 + 200) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        item_t it;
        exu_pkg::alu_op_t md_ops[5];
        void'($urandom(28));
        arst_n = 1'b0; in_valid = 1'b0; flush = 1'b0; word = 1'b0;
        op = exu_pkg::alu_add; sel_a = a_rs1; sel_b = b_rs2;
        pc = '0; rs1 = '0; rs2 = '0; imm = '0;
        wb_cyc = 1'b0; wb_stb = 1'b0; wb_we = 1'b0; wb_adr = '0; wb_dat_w = '0;
        md_ops = '{exu_pkg::alu_mul, exu_pkg::alu_div, exu_pkg::alu_divu,
                   exu_pkg::alu_rem, exu_pkg::alu_remu};

        add("add_rs1_rs2", exu_pkg::alu_add, a_rs1, b_rs2, 0, 0, 100, 23, 0, 123);
        add("sub_pc_imm", exu_pkg::alu_sub, a_pc, b_imm, 0, 64'h1000, 0, 0, 64'h10, 64'hff0);
        add("pass_a_pc", exu_pkg::alu_pass_a, a_pc, b_imm, 0, 64'h8000_0000_0000_1234, 0, 0, 0,
            64'h8000_0000_0000_1234);
        add("pass_b_csr", exu_pkg::alu_pass_b, a_rs1, b_csr, 0, 0, 0, 0, 0, csr_val);
        add("pass_a_word", exu_pkg::alu_pass_a, a_rs1, b_imm, 1, 0, 64'habcd_0000_1234_5678, 0, 0,
            64'h1234_5678);
        add("xor_imm", exu_pkg::alu_xor, a_rs1, b_imm, 0, 0, 64'hff00, 0, 64'h0ff0, 64'hf0f0);
        add("or_rs2", exu_pkg::alu_or, a_rs1, b_rs2, 0, 0, 64'hf0, 64'h0f, 0, 64'hff);
        add("and_csr", exu_pkg::alu_and, a_rs1, b_csr, 0, 0, '1, 0, 0, csr_val);
        add("add_pc_csr", exu_pkg::alu_add, a_pc, b_csr, 0, 64'h100, 0, 0, 0,
            64'h0000_0010_0000_0103);
        add("sll_imm", exu_pkg::alu_sll, a_rs1, b_imm, 0, 0, 1, 0, 64'h43, 8);
        add("srl_rs2", exu_pkg::alu_srl, a_rs1, b_rs2, 0, 0, 64'h8000_0000_0000_0000, 63, 0, 1);
        add("sra_imm", exu_pkg::alu_sra, a_rs1, b_imm, 0, 0, 64'h8000_0000_0000_0000, 0, 4,
            64'hf800_0000_0000_0000);
        add("sra_word", exu_pkg::alu_sra, a_rs1, b_imm, 1, 0, 64'h1234_5678_8000_0000, 0, 4,
            64'h0000_0000_f800_0000);
        add("add_word", exu_pkg::alu_add, a_rs1, b_rs2, 1, 0, 64'hffff_ffff_0000_0005, 1, 0, 6);
        add("slt", exu_pkg::alu_slt, a_rs1, b_rs2, 0, 0, '1, 1, 0, 1);
        add("sltu", exu_pkg::alu_sltu, a_rs1, b_rs2, 0, 0, '1, 1, 0, 0);
        add("eq_imm", exu_pkg::alu_eq, a_rs1, b_imm, 0, 0, 77, 0, 77, 1);
        add("ge", exu_pkg::alu_ge, a_rs1, b_rs2, 0, 0, 64'hffff_ffff_ffff_fffb, 3, 0, 0);
        add("geu", exu_pkg::alu_geu, a_rs1, b_rs2, 0, 0, 64'hffff_ffff_ffff_fffb, 3, 0, 1);
        add("mul", exu_pkg::alu_mul, a_rs1, b_rs2, 0, 0, 7, 6, 0, 42);
        add("mul_neg", exu_pkg::alu_mul, a_rs1, b_rs2, 0, 0, 64'hffff_ffff_ffff_fffd, 5, 0,
            64'hffff_ffff_ffff_fff1);
        add("div_neg", exu_pkg::alu_div, a_rs1, b_rs2, 0, 0, 64'hffff_ffff_ffff_ffec, 3, 0,
            64'hffff_ffff_ffff_fffa);
        add("rem_neg", exu_pkg::alu_rem, a_rs1, b_rs2, 0, 0, 64'hffff_ffff_ffff_ffec, 3, 0,
            64'hffff_ffff_ffff_fffe);
        add("divu", exu_pkg::alu_divu, a_rs1, b_rs2, 0, 0, 100, 7, 0, 14);
        add("remu", exu_pkg::alu_remu, a_rs1, b_rs2, 0, 0, 100, 7, 0, 2);
        add("div_zero", exu_pkg::alu_div, a_rs1, b_rs2, 0, 0, 5, 0, 0, '1);
        add("rem_zero", exu_pkg::alu_rem, a_rs1, b_rs2, 0, 0, 5, 0, 0, 5);
        add("divu_zero", exu_pkg::alu_divu, a_rs1, b_rs2, 0, 0, 9, 0, 0, '1);
        add("remu_zero", exu_pkg::alu_remu, a_rs1, b_rs2, 0, 0, 9, 0, 0, 9);
        add("div_ovf", exu_pkg::alu_div, a_rs1, b_rs2, 0, 0, 64'h8000_0000_0000_0000, '1, 0,
            64'h8000_0000_0000_0000);
        add("rem_ovf", exu_pkg::alu_rem, a_rs1, b_rs2, 0, 0, 64'h8000_0000_0000_0000, '1, 0, 0);
        tbl_ready = 1'b1;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // scratch operand feeds the csr select
        wb_access(1, exu_csr_pkg::addr_scratch_lo, csr_val[31:0]);
        wb_access(1, exu_csr_pkg::addr_scratch_hi, csr_val[63:32]);
        wb_access(0, exu_csr_pkg::addr_scratch_lo, 0);
        u_mon.check_value("scratch_lo_read", csr_val[31:0], rd);
        wb_access(0, exu_csr_pkg::addr_scratch_hi, 0);
        u_mon.check_value("scratch_hi_read", csr_val[63:32], rd);

        foreach (tbl[i]) issue(tbl_name[i], tbl[i], 0, 1);

        for (int i = 0; i < n_rand; i++) begin
            it = '{md_ops[$urandom % 5], a_rs1, b_rs2, 0, 0, {$urandom, $urandom},
                   {$urandom, $urandom}, 0, 0};
            if ($urandom % 4 == 0) it.rs2 = $urandom % 16;
            it.exp = ref_muldiv(it.op, it.rs1, it.rs2);
            issue($sformatf("rand_%0d_%s", i, it.op.name()), it, 0, 1);
        end

        // abort a divide halfway, then an add must still work
        drain();
        issue("div_flushed", '{exu_pkg::alu_div, a_rs1, b_rs2, 0, 0, 1000, 7, 0, 0}, 0, 0);
        repeat (20) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        issue("add_after_flush", '{exu_pkg::alu_add, a_rs1, b_imm, 0, 0, 40, 0, 2, 42}, 0, 1);

        drain();
        wb_access(1, exu_csr_pkg::addr_ctrl, 0);
        issue("mul_disabled", '{exu_pkg::alu_mul, a_rs1, b_rs2, 0, 0, 3, 4, 0, 0}, 1, 1);
        drain();
        wb_access(1, exu_csr_pkg::addr_ctrl, 1);
        issue("mul_enabled", '{exu_pkg::alu_mul, a_rs1, b_rs2, 0, 0, 3, 4, 0, 12}, 0, 1);

        drain();
        wb_access(0, exu_csr_pkg::addr_retired, 0);
        u_mon.check_value("retired_count", u_mon.n_results, rd);
        wb_access(1, exu_csr_pkg::addr_retired, 32'h1234);
        wb_access(0, exu_csr_pkg::addr_retired, 0);
        u_mon.check_value("retired_after_write", u_mon.n_results, rd);

        repeat (4) @(posedge clk);
        total = u_mon.value_errors + u_mon.other_errors + tb_errors +
                u_dut.u_alu.u_chk.fails + u_dut.u_csr.u_chk.fails;
        $display("errors: %0d value, %0d monitor, %0d bus, %0d assertion",
                 u_mon.value_errors, u_mon.other_errors, tb_errors,
                 u_dut.u_alu.u_chk.fails + u_dut.u_csr.u_chk.fails);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
hw/exu_pkg.sv
hw/exu_csr_pkg.sv
hw/exu_csr_regs.sv
hw/exu_muldiv.sv
hw/exu_alu.sv
hw/exu_top.sv
testbench/exu_monitor.sv
testbench/exu_chk.sv
testbench/exu_tb.sv
